//--- src/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// Memory operation carried down from decode
	typedef enum logic [3:0] {
		MEM_NONE,
		MEM_LB,
		MEM_LBU,
		MEM_LH,
		MEM_LHU,
		MEM_LW,
		MEM_SB,
		MEM_SH,
		MEM_SW
	} mem_op_t;

	typedef enum logic [1:0] {
		CP0_NONE,
		CP0_MTC0,
		CP0_MFC0,
		CP0_ERET
	} cp0_op_t;

	// Cause.ExcCode values
	typedef enum logic [4:0] {
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_OV   = 5'd12
	} exc_code_t;

	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	localparam logic [4:0] CP0_BADVADDR = 5'd8;
	localparam logic [4:0] CP0_STATUS   = 5'd12;
	localparam logic [4:0] CP0_CAUSE    = 5'd13;
	localparam logic [4:0] CP0_EPC      = 5'd14;

	localparam int STATUS_EXL_BIT = 1;
	localparam int CAUSE_BD_BIT   = 31;

	// BEV set out of reset
	localparam logic [31:0] STATUS_RESET = 32'h0040_0000;
	localparam logic [31:0] EXC_VECTOR   = 32'hBFC0_0380;

endpackage

`default_nettype wire

//--- src/mem_access_decode.sv
`default_nettype none

module mem_access_decode import cpu_pkg::*; (
	input  mem_op_t     mem_op,
	input  logic [31:0] addr,
	output logic        req,
	output logic        wr,
	output logic [1:0]  size,
	output logic        load_sign,
	output logic        adel,
	output logic        ades
);

	logic valid;
	logic misaligned;

	always_comb begin
		valid = 1'b1;
		wr = 1'b0;
		size = SIZE_WORD;
		load_sign = 1'b0;
		case (mem_op)
			MEM_LB: begin
				size = SIZE_BYTE;
				load_sign = 1'b1;
			end
			MEM_LBU: size = SIZE_BYTE;
			MEM_LH: begin
				size = SIZE_HALF;
				load_sign = 1'b1;
			end
			MEM_LHU: size = SIZE_HALF;
			MEM_LW: size = SIZE_WORD;
			MEM_SB: begin
				size = SIZE_BYTE;
				wr = 1'b1;
			end
			MEM_SH: begin
				size = SIZE_HALF;
				wr = 1'b1;
			end
			MEM_SW: wr = 1'b1;
			default: valid = 1'b0;
		endcase
	end

	// Bytes never fault, halfwords need bit 0 clear
	assign misaligned = (size == SIZE_HALF && addr[0]) ||
		(size == SIZE_WORD && addr[1:0] != 2'b00);

	assign adel = valid && !wr && misaligned;
	assign ades = valid && wr && misaligned;
	assign req = valid && !misaligned;

endmodule

`default_nettype wire

//--- src/store_align.sv
`default_nettype none

module store_align import cpu_pkg::*; (
	input  logic [31:0] store_data,
	input  logic [1:0]  size,
	input  logic [1:0]  offset,
	output logic [31:0] wdata,
	output logic [3:0]  be
);

	always_comb begin
		case (size)
			SIZE_BYTE: begin
				wdata = {4{store_data[7:0]}};
				be = 4'b0001 << offset;
			end
			SIZE_HALF: begin
				wdata = {2{store_data[15:0]}};
				// Upper half when offset is 2
				be = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata = store_data;
				be = 4'b1111;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/cp0_exc.sv
`default_nettype none

module cp0_exc import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        stall,
	input  cp0_op_t     cp0_op,
	input  logic        adel,
	input  logic        ades,
	input  logic        ovf,
	input  logic        syscall,
	input  logic        brk,
	input  logic [31:0] pc,
	input  logic        in_delay_slot,
	input  logic [31:0] addr,
	input  logic [4:0]  cp0_rd,
	input  logic [31:0] cp0_wdata,
	output logic        exc_valid,
	output logic        eret_valid,
	output logic [31:0] epc,
	output logic [31:0] cp0_rdata
);

	logic [31:0] status;
	logic [31:0] cause;
	logic [31:0] badvaddr;
	logic        exc_raw;
	exc_code_t   exc_code;

	// Address error first, then overflow, syscall, break
	always_comb begin
		exc_raw = 1'b1;
		exc_code = EXC_ADEL;
		if (adel)
			exc_code = EXC_ADEL;
		else if (ades)
			exc_code = EXC_ADES;
		else if (ovf)
			exc_code = EXC_OV;
		else if (syscall)
			exc_code = EXC_SYS;
		else if (brk)
			exc_code = EXC_BP;
		else
			exc_raw = 1'b0;
	end

	assign exc_valid = exc_raw && !stall;
	assign eret_valid = cp0_op == CP0_ERET && !exc_raw && !stall;

	always_ff @(posedge clk) begin
		if (reset) begin
			status <= STATUS_RESET;
			cause <= '0;
			epc <= '0;
			badvaddr <= '0;
		end else if (exc_valid) begin
			epc <= in_delay_slot ? pc - 32'd4 : pc;
			cause[CAUSE_BD_BIT] <= in_delay_slot;
			// ExcCode field
			cause[6:2] <= exc_code;
			status[STATUS_EXL_BIT] <= 1'b1;
			if (adel || ades)
				badvaddr <= addr;
		end else if (eret_valid) begin
			status[STATUS_EXL_BIT] <= 1'b0;
		end else if (!stall && cp0_op == CP0_MTC0) begin
			case (cp0_rd)
				CP0_STATUS: status <= cp0_wdata;
				// Only the software interrupt bits are writable
				CP0_CAUSE: cause[9:8] <= cp0_wdata[9:8];
				CP0_EPC: epc <= cp0_wdata;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (cp0_rd)
			CP0_BADVADDR: cp0_rdata = badvaddr;
			CP0_STATUS: cp0_rdata = status;
			CP0_CAUSE: cp0_rdata = cause;
			CP0_EPC: cp0_rdata = epc;
			default: cp0_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/load_extend.sv
`default_nettype none

module load_extend import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        stall,
	input  logic        req,
	input  logic        wr,
	input  logic [1:0]  size,
	input  logic        load_sign,
	input  logic [1:0]  offset,
	input  logic [31:0] data_rdata,
	output logic [31:0] load_data,
	output logic        load_valid
);

	logic        pend;
	logic [1:0]  size_q;
	logic        sign_q;
	logic [1:0]  offset_q;
	logic [7:0]  byte_sel;
	logic [15:0] half_sel;

	// req is already low during a stall
	always_ff @(posedge clk) begin
		if (reset)
			pend <= 1'b0;
		else
			pend <= req && !wr;
	end

	always_ff @(posedge clk) begin
		if (!stall && req && !wr) begin
			size_q <= size;
			sign_q <= load_sign;
			offset_q <= offset;
		end
	end

	assign byte_sel = data_rdata[offset_q*8 +: 8];
	assign half_sel = offset_q[1] ? data_rdata[31:16] : data_rdata[15:0];

	always_comb begin
		case (size_q)
			SIZE_BYTE: load_data = {{24{sign_q & byte_sel[7]}}, byte_sel};
			SIZE_HALF: load_data = {{16{sign_q & half_sel[15]}}, half_sel};
			default: load_data = data_rdata;
		endcase
	end

	assign load_valid = pend && !stall;

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`default_nettype none

module mem_stage import cpu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        stall,
	input  mem_op_t     mem_op,
	input  cp0_op_t     cp0_op,
	input  logic [31:0] addr,
	input  logic [31:0] store_data,
	input  logic [31:0] pc,
	input  logic        in_delay_slot,
	input  logic        ovf,
	input  logic        syscall,
	input  logic        brk,
	input  logic [4:0]  cp0_rd,
	input  logic [31:0] cp0_wdata,
	input  logic [31:0] data_rdata,
	output logic        data_req,
	output logic        data_wr,
	output logic [1:0]  data_size,
	output logic [31:0] data_addr,
	output logic [31:0] data_wdata,
	output logic [3:0]  data_be,
	output logic [31:0] load_data,
	output logic        load_valid,
	output logic [31:0] cp0_rdata,
	output logic        exc_valid,
	output logic [31:0] exc_target,
	output logic        eret_valid
);

	logic        dec_req;
	logic        dec_sign;
	logic        adel;
	logic        ades;
	logic [31:0] epc;

	mem_access_decode u_decode (
		.mem_op    (mem_op),
		.addr      (addr),
		.req       (dec_req),
		.wr        (data_wr),
		.size      (data_size),
		.load_sign (dec_sign),
		.adel      (adel),
		.ades      (ades)
	);

	store_align u_store_align (
		.store_data (store_data),
		.size       (data_size),
		.offset     (addr[1:0]),
		.wdata      (data_wdata),
		.be         (data_be)
	);

	cp0_exc u_cp0 (
		.clk           (clk),
		.reset         (reset),
		.stall         (stall),
		.cp0_op        (cp0_op),
		.adel          (adel),
		.ades          (ades),
		.ovf           (ovf),
		.syscall       (syscall),
		.brk           (brk),
		.pc            (pc),
		.in_delay_slot (in_delay_slot),
		.addr          (addr),
		.cp0_rd        (cp0_rd),
		.cp0_wdata     (cp0_wdata),
		.exc_valid     (exc_valid),
		.eret_valid    (eret_valid),
		.epc           (epc),
		.cp0_rdata     (cp0_rdata)
	);

	// A faulting instruction never reaches memory
	assign data_req = dec_req && !exc_valid && !stall;
	assign data_addr = addr;
	assign exc_target = exc_valid ? EXC_VECTOR : epc;

	load_extend u_load_extend (
		.clk        (clk),
		.reset      (reset),
		.stall      (stall),
		.req        (data_req),
		.wr         (data_wr),
		.size       (data_size),
		.load_sign  (dec_sign),
		.offset     (addr[1:0]),
		.data_rdata (data_rdata),
		.load_data  (load_data),
		.load_valid (load_valid)
	);

endmodule

`default_nettype wire

//--- test/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage import cpu_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND = 40;
	localparam int TEST_CYCLES = N_RAND * 6 + 80;

	logic clk, reset, stall, in_delay_slot, ovf, syscall, brk;
	mem_op_t mem_op;
	cp0_op_t cp0_op;
	logic [31:0] addr, store_data, pc, cp0_wdata, data_rdata;
	logic [4:0] cp0_rd;
	logic data_req, data_wr, load_valid, exc_valid, eret_valid;
	logic [1:0] data_size;
	logic [3:0] data_be;
	logic [31:0] data_addr, data_wdata, load_data, cp0_rdata, exc_target;

	logic [31:0] mem [0:255];
	int errors = 0;
	int checks = 0;

	// Shadow CP0 state and the load in flight
	logic [31:0] sh_epc, sh_status, sh_cause, sh_badvaddr, ld_word;
	logic ld_pend;
	mem_op_t ld_op;
	logic [1:0] ld_off;

	mem_op_t store_ops[3] = '{MEM_SB, MEM_SH, MEM_SW};
	mem_op_t load_ops[5] = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
	mem_op_t bad_ops[5] = '{MEM_LH, MEM_LHU, MEM_LW, MEM_SH, MEM_SW};

	mem_stage dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		data_rdata = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
	end

	// Memory model, one cycle read latency
	always @(posedge clk) begin
		if (data_req && data_wr) begin
			for (int b = 0; b < 4; b++)
				if (data_be[b])
					mem[data_addr[9:2]][b*8 +: 8] <= data_wdata[b*8 +: 8];
		end else if (data_req) begin
			data_rdata <= mem[data_addr[9:2]];
		end
	end

	function automatic int op_size(mem_op_t op);
		case (op)
			MEM_LB, MEM_LBU, MEM_SB: return 0;
			MEM_LH, MEM_LHU, MEM_SH: return 1;
			default: return 2;
		endcase
	endfunction

	function automatic bit is_store(mem_op_t op);
		return op == MEM_SB || op == MEM_SH || op == MEM_SW;
	endfunction

	function automatic int ref_exc(mem_op_t op, logic [31:0] a, logic o, logic s, logic b);
		logic [31:0] mask;
		mask = (32'd1 << op_size(op)) - 32'd1;
		if (op != MEM_NONE && (a & mask) != 32'd0)
			return is_store(op) ? 5 : 4;
		if (o)
			return 12;
		if (s)
			return 8;
		if (b)
			return 9;
		return -1;
	endfunction

	// Each lane repeats the low bytes of the store operand
	function automatic logic [31:0] ref_wdata(logic [31:0] d, mem_op_t op);
		int bytes;
		logic [31:0] w;
		bytes = 1 << op_size(op);
		for (int k = 0; k < 4; k++)
			w[k*8 +: 8] = d[(k % bytes)*8 +: 8];
		return w;
	endfunction

	function automatic logic [3:0] ref_be(mem_op_t op, logic [1:0] off);
		int bytes;
		logic [3:0] be;
		bytes = 1 << op_size(op);
		be = '0;
		for (int k = 0; k < 4; k++)
			be[k] = k >= off && k < off + bytes;
		return be;
	endfunction

	function automatic logic [31:0] ref_load(logic [31:0] w, mem_op_t op, logic [1:0] off);
		logic [7:0] b;
		logic [15:0] h;
		b = w >> (off * 8);
		h = off[1] ? w[31:16] : w[15:0];
		case (op)
			MEM_LB: return {{24{b[7]}}, b};
			MEM_LBU: return {24'h0, b};
			MEM_LH: return {{16{h[15]}}, h};
			MEM_LHU: return {16'h0, h};
			default: return w;
		endcase
	endfunction

	function automatic logic [1:0] pick_offset(mem_op_t op);
		logic [31:0] r;
		r = $urandom;
		case (op_size(op))
			0: return r[1:0];
			1: return {r[0], 1'b0};
			default: return 2'b00;
		endcase
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic idle();
		{stall, in_delay_slot, ovf, syscall, brk} = '0;
		mem_op = MEM_NONE;
		cp0_op = CP0_NONE;
		{addr, store_data, pc, cp0_wdata} = '0;
		cp0_rd = '0;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		idle();
	endtask

	// Outputs are settled by the falling edge
	always @(negedge clk) begin
		int exc;
		bit exp_req, exp_eret, exp_lv;
		logic [31:0] exp_rd;
		if (reset) begin
			sh_status = 32'h0040_0000;
			{sh_epc, sh_cause, sh_badvaddr} = '0;
			ld_pend = 1'b0;
		end else begin
			exc = stall ? -1 : ref_exc(mem_op, addr, ovf, syscall, brk);
			exp_req = !stall && mem_op != MEM_NONE && exc < 0;
			exp_eret = !stall && cp0_op == CP0_ERET && exc < 0;
			exp_lv = ld_pend && !stall;
			check_value("data_req", data_req, exp_req);
			check_value("exc_valid", exc_valid, exc >= 0);
			check_value("eret_valid", eret_valid, exp_eret);
			check_value("load_valid", load_valid, exp_lv);
			if (exp_req) begin
				check_value("data_wr", data_wr, is_store(mem_op));
				check_value("data_size", data_size, op_size(mem_op));
				check_value("data_addr", data_addr, addr);
				if (is_store(mem_op)) begin
					check_value("data_wdata", data_wdata, ref_wdata(store_data, mem_op));
					check_value("data_be", data_be, ref_be(mem_op, addr[1:0]));
				end
			end
			if (exc >= 0)
				check_value("exc_target", exc_target, EXC_VECTOR);
			else if (exp_eret)
				check_value("exc_target", exc_target, sh_epc);
			if (exp_lv)
				check_value("load_data", load_data, ref_load(ld_word, ld_op, ld_off));
			case (cp0_rd)
				CP0_BADVADDR: exp_rd = sh_badvaddr;
				CP0_STATUS: exp_rd = sh_status;
				CP0_CAUSE: exp_rd = sh_cause;
				CP0_EPC: exp_rd = sh_epc;
				default: exp_rd = '0;
			endcase
			check_value("cp0_rdata", cp0_rdata, exp_rd);
			ld_pend = exp_req && !is_store(mem_op);
			if (ld_pend) begin
				ld_word = mem[addr[9:2]];
				ld_op = mem_op;
				ld_off = addr[1:0];
			end
			if (exc >= 0) begin
				sh_epc = in_delay_slot ? pc - 32'd4 : pc;
				sh_cause[31] = in_delay_slot;
				sh_cause[6:2] = exc[4:0];
				sh_status[1] = 1'b1;
				if (exc == 4 || exc == 5)
					sh_badvaddr = addr;
			end else if (exp_eret) begin
				sh_status[1] = 1'b0;
			end else if (!stall && cp0_op == CP0_MTC0) begin
				case (cp0_rd)
					CP0_STATUS: sh_status = cp0_wdata;
					CP0_CAUSE: sh_cause[9:8] = cp0_wdata[9:8];
					CP0_EPC: sh_epc = cp0_wdata;
					default: ;
				endcase
			end
		end
	end

	initial begin
		#(TEST_CYCLES * 10 + 500);
		$display("Timeout: the test sequence did not finish in time");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		logic [31:0] base;
		void'($urandom(32'h1435_57d7));
		reset = 1'b1;
		idle();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		cp0_op = CP0_MFC0;
		cp0_rd = CP0_STATUS;
		// Stores of every size, then every load type from that word
		for (int i = 0; i < N_RAND; i++) begin
			next_cycle();
			base = {22'h0, 8'($urandom), 2'b00};
			mem_op = store_ops[$urandom_range(2)];
			addr = base | pick_offset(mem_op);
			store_data = $urandom;
			for (int j = 0; j < 5; j++) begin
				next_cycle();
				mem_op = load_ops[j];
				addr = base | pick_offset(mem_op);
			end
		end
		for (int j = 0; j < 5; j++) begin
			next_cycle();
			mem_op = bad_ops[j];
			addr = $urandom & 32'hFFFF_FFFC;
			addr[1:0] = op_size(mem_op) == 1 ? {1'($urandom), 1'b1} : 2'($urandom_range(3, 1));
			next_cycle();
			cp0_op = CP0_MFC0;
			cp0_rd = CP0_CAUSE;
			next_cycle();
			cp0_rd = CP0_BADVADDR;
		end
		// Flag combinations, the last one with an address error too
		for (int c = 1; c <= 8; c++) begin
			next_cycle();
			mem_op = MEM_LW;
			addr = $urandom & 32'hFFFF_FFFC;
			if (c == 8)
				addr[1:0] = 2'b10;
			{brk, syscall, ovf} = (c == 8) ? 3'b111 : c[2:0];
			pc = $urandom & 32'hFFFF_FFFC;
			in_delay_slot = c[0];
			next_cycle();
			cp0_op = CP0_MFC0;
			cp0_rd = CP0_CAUSE;
			next_cycle();
			cp0_rd = CP0_EPC;
		end
		next_cycle();
		cp0_op = CP0_MTC0;
		cp0_rd = CP0_EPC;
		cp0_wdata = $urandom & 32'hFFFF_FFFC;
		next_cycle();
		cp0_op = CP0_ERET;
		next_cycle();
		cp0_op = CP0_MFC0;
		cp0_rd = CP0_STATUS;
		next_cycle();
		cp0_op = CP0_ERET;
		syscall = 1'b1;
		next_cycle();
		mem_op = MEM_LW;
		addr = {22'h0, 8'($urandom), 2'b00};
		next_cycle();
		stall = 1'b1;
		mem_op = MEM_LW;
		ovf = 1'b1;
		cp0_op = CP0_MTC0;
		cp0_rd = CP0_EPC;
		cp0_wdata = $urandom;
		next_cycle();
		stall = 1'b1;
		cp0_op = CP0_ERET;
		cp0_rd = CP0_STATUS;
		next_cycle();
		cp0_op = CP0_MFC0;
		cp0_rd = CP0_EPC;
		next_cycle();
		cp0_op = CP0_MFC0;
		cp0_rd = CP0_STATUS;
		repeat (2) next_cycle();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/cpu_pkg.sv
src/mem_access_decode.sv
src/store_align.sv
src/cp0_exc.sv
src/load_extend.sv
src/mem_stage.sv
test/tb_mem_stage.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - src/cpu_pkg.sv
  - src/mem_access_decode.sv
  - src/store_align.sv
  - src/cp0_exc.sv
  - src/load_extend.sv
  - src/mem_stage.sv
  - target: test
    files:
      - test/tb_mem_stage.sv
